//--- hdl/sram_pkg.sv
package sram_pkg;

    // ==========================================================
    // Bus widths
    // ==========================================================
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [3:0]        axi_id_t;
    typedef logic [15:0]       axi_addr_t;
    typedef logic [7:0]        axi_len_t;
    typedef logic [2:0]        axi_size_t;
    typedef logic [1:0]        axi_burst_t;
    typedef logic [1:0]        axi_resp_t;
    typedef logic [DATA_W-1:0] axi_data_t;
    typedef logic [STRB_W-1:0] axi_strb_t;

    // Burst types, code 2'b11 is reserved
    localparam axi_burst_t BURST_FIXED = 2'b00;
    localparam axi_burst_t BURST_INCR  = 2'b01;
    localparam axi_burst_t BURST_WRAP  = 2'b10;

    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

    // Full-width beats only
    localparam axi_size_t SIZE_8B = 3'd3;

    // ==========================================================
    // Channel payloads
    // ==========================================================
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } sram_cmd_t;

    typedef struct packed {
        axi_data_t data;
        axi_strb_t strb;
    } sram_wbeat_t;

    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_t resp;
        logic      last;
    } sram_rbeat_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } sram_bresp_t;

endpackage

//--- hdl/sram_burst_addr.sv
`timescale 1ns/1ps

module sram_burst_addr (
    input  sram_pkg::axi_addr_t  i_addr,
    input  sram_pkg::axi_len_t   i_len,
    input  sram_pkg::axi_burst_t i_burst,
    output sram_pkg::axi_addr_t  o_next_addr
);

    // Bytes per full-width beat
    localparam sram_pkg::axi_addr_t BEAT_BYTES = sram_pkg::axi_addr_t'(sram_pkg::STRB_W);

    sram_pkg::axi_addr_t w_incr_addr;
    sram_pkg::axi_addr_t w_wrap_bytes;
    sram_pkg::axi_addr_t w_wrap_mask;
    sram_pkg::axi_addr_t w_wrap_base;

    assign w_incr_addr = i_addr + BEAT_BYTES;

    // Wrap window is (len + 1) beats, aligned to its own size
    assign w_wrap_bytes = (sram_pkg::axi_addr_t'(i_len) + 16'd1) * BEAT_BYTES;
    assign w_wrap_mask  = w_wrap_bytes - 16'd1;
    assign w_wrap_base  = i_addr & ~w_wrap_mask;

    always_comb begin
        case (i_burst)
            sram_pkg::BURST_FIXED: begin
                o_next_addr = i_addr;
            end
            sram_pkg::BURST_WRAP: begin
                // Carry out of the window drops, so the top wraps to base
                o_next_addr = w_wrap_base | (w_incr_addr & w_wrap_mask);
            end
            default: begin
                // INCR, reserved code never writes or reads anyway
                o_next_addr = w_incr_addr;
            end
        endcase
    end

endmodule

//--- hdl/sram_array.sv
`timescale 1ns/1ps

module sram_array #(
    parameter int MEM_ADDR_W = 8
) (
    input  logic                  i_aclk,
    // Write port
    input  logic                  i_we,
    input  logic [MEM_ADDR_W-1:0] i_waddr,
    input  sram_pkg::axi_data_t   i_wdata,
    input  sram_pkg::axi_strb_t   i_wstrb,
    // Read port
    input  logic [MEM_ADDR_W-1:0] i_raddr,
    output sram_pkg::axi_data_t   o_rdata
);

    localparam int DEPTH = 2 ** MEM_ADDR_W;

    // ==========================================================
    // Storage
    // ==========================================================
    sram_pkg::axi_data_t r_ram [0:DEPTH-1];

    // Byte lanes written only where the strobe is set
    always_ff @(posedge i_aclk) begin
        if (i_we) begin
            for (int i = 0; i < sram_pkg::STRB_W; i++) begin
                if (i_wstrb[i]) begin
                    r_ram[i_waddr][8*i +: 8] <= i_wdata[8*i +: 8];
                end
            end
        end
    end

    // Registered read, one word every cycle
    always_ff @(posedge i_aclk) begin
        o_rdata <= r_ram[i_raddr];
    end

endmodule

//--- hdl/sram_wr_ctrl.sv
`timescale 1ns/1ps

module sram_wr_ctrl #(
    parameter int MEM_ADDR_W = 8
) (
    input  logic                  i_aclk,
    input  logic                  i_areset_n,
    // Write address
    input  sram_pkg::sram_cmd_t   i_aw,
    input  logic                  i_awvalid,
    output logic                  o_awready,
    // Write data
    input  sram_pkg::sram_wbeat_t i_w,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    // Write response
    output sram_pkg::sram_bresp_t o_b,
    output logic                  o_bvalid,
    input  logic                  i_bready,
    // Memory write port
    output logic                  o_mem_we,
    output logic [MEM_ADDR_W-1:0] o_mem_addr,
    output sram_pkg::axi_data_t   o_mem_wdata,
    output sram_pkg::axi_strb_t   o_mem_wstrb
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WR_DATA,
        S_WR_RESP
    } sram_wr_state_t;

    sram_wr_state_t r_state_curr;
    sram_wr_state_t r_state_next;

    // Command held for the whole burst
    sram_pkg::axi_id_t    r_awid;
    sram_pkg::axi_addr_t  r_awaddr;
    sram_pkg::axi_len_t   r_awlen;
    sram_pkg::axi_burst_t r_awburst;
    logic                 r_awerr;
    sram_pkg::axi_len_t   r_awlen_cnt;

    sram_pkg::axi_addr_t  w_awaddr_next;
    logic                 w_awerr;
    logic                 w_awshake;
    logic                 w_wshake;
    logic                 w_wend;
    logic                 w_bshake;

    assign w_awshake = i_awvalid && o_awready;
    assign w_wshake  = i_wvalid && o_wready;
    assign w_wend    = w_wshake && (r_awlen_cnt == r_awlen);
    assign w_bshake  = o_bvalid && i_bready;

    // Bad size, reserved burst type, or start beyond the memory
    assign w_awerr = (i_aw.size != sram_pkg::SIZE_8B) ||
                     ((i_aw.burst != sram_pkg::BURST_FIXED) &&
                      (i_aw.burst != sram_pkg::BURST_INCR) &&
                      (i_aw.burst != sram_pkg::BURST_WRAP)) ||
                     ((i_aw.addr >> (MEM_ADDR_W + 3)) != '0);

    sram_burst_addr burst_addr_i (
        .i_addr      (r_awaddr),
        .i_len       (r_awlen),
        .i_burst     (r_awburst),
        .o_next_addr (w_awaddr_next)
    );

    // ==========================================================
    // State machine
    // ==========================================================
    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_state_curr <= S_IDLE;
        end
        else begin
            r_state_curr <= r_state_next;
        end
    end

    always_comb begin
        r_state_next = r_state_curr;
        case (r_state_curr)
            S_IDLE:    if (w_awshake) r_state_next = S_WR_DATA;
            S_WR_DATA: if (w_wend)    r_state_next = S_WR_RESP;
            S_WR_RESP: if (w_bshake)  r_state_next = S_IDLE;
            default:   r_state_next = S_IDLE;
        endcase
    end

    // Beat counter against awlen
    always_ff @(posedge i_aclk) begin
        if (!i_areset_n || w_awshake) begin
            r_awlen_cnt <= '0;
        end
        else if (w_wshake) begin
            r_awlen_cnt <= r_awlen_cnt + 8'd1;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (w_awshake) begin
            r_awid    <= i_aw.id;
            r_awaddr  <= i_aw.addr;
            r_awlen   <= i_aw.len;
            r_awburst <= i_aw.burst;
            r_awerr   <= w_awerr;
        end
        else if (w_wshake) begin
            r_awaddr <= w_awaddr_next;
        end
    end

    // ==========================================================
    // Outputs
    // ==========================================================
    assign o_awready = (r_state_curr == S_IDLE);
    assign o_wready  = (r_state_curr == S_WR_DATA);
    assign o_bvalid  = (r_state_curr == S_WR_RESP);

    assign o_b.id   = r_awid;
    assign o_b.resp = r_awerr ? sram_pkg::RESP_SLVERR : sram_pkg::RESP_OKAY;

    // Error bursts are drained without touching the array
    assign o_mem_we    = w_wshake && !r_awerr;
    assign o_mem_addr  = r_awaddr[MEM_ADDR_W+2:3];
    assign o_mem_wdata = i_w.data;
    assign o_mem_wstrb = i_w.strb;

endmodule

//--- hdl/sram_rd_ctrl.sv
`timescale 1ns/1ps

module sram_rd_ctrl #(
    parameter int MEM_ADDR_W = 8
) (
    input  logic                  i_aclk,
    input  logic                  i_areset_n,
    // Read address
    input  sram_pkg::sram_cmd_t   i_ar,
    input  logic                  i_arvalid,
    output logic                  o_arready,
    // Read data
    output sram_pkg::sram_rbeat_t o_r,
    output logic                  o_rvalid,
    input  logic                  i_rready,
    // Memory read port
    output logic [MEM_ADDR_W-1:0] o_mem_raddr,
    input  sram_pkg::axi_data_t   i_mem_rdata
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RD_ADDR,
        S_RD_DATA
    } sram_rd_state_t;

    sram_rd_state_t r_state_curr;
    sram_rd_state_t r_state_next;

    sram_pkg::axi_id_t    r_arid;
    sram_pkg::axi_addr_t  r_araddr;
    sram_pkg::axi_len_t   r_arlen;
    sram_pkg::axi_burst_t r_arburst;
    logic                 r_arerr;
    sram_pkg::axi_len_t   r_arlen_cnt;

    sram_pkg::axi_addr_t  w_araddr_next;
    sram_pkg::axi_addr_t  w_raddr;
    logic                 w_arerr;
    logic                 w_arshake;
    logic                 w_rshake;
    logic                 w_rlast;
    logic                 w_rend;

    assign w_arshake = i_arvalid && o_arready;
    assign w_rshake  = o_rvalid && i_rready;
    assign w_rlast   = (r_arlen_cnt == r_arlen);
    assign w_rend    = w_rshake && w_rlast;

    // Same error rule as the write side
    assign w_arerr = (i_ar.size != sram_pkg::SIZE_8B) ||
                     ((i_ar.burst != sram_pkg::BURST_FIXED) &&
                      (i_ar.burst != sram_pkg::BURST_INCR) &&
                      (i_ar.burst != sram_pkg::BURST_WRAP)) ||
                     ((i_ar.addr >> (MEM_ADDR_W + 3)) != '0);

    sram_burst_addr burst_addr_i (
        .i_addr      (r_araddr),
        .i_len       (r_arlen),
        .i_burst     (r_arburst),
        .o_next_addr (w_araddr_next)
    );

    // ==========================================================
    // State machine
    // ==========================================================
    always_ff @(posedge i_aclk) begin
        if (!i_areset_n) begin
            r_state_curr <= S_IDLE;
        end
        else begin
            r_state_curr <= r_state_next;
        end
    end

    always_comb begin
        r_state_next = r_state_curr;
        case (r_state_curr)
            S_IDLE:    if (w_arshake) r_state_next = S_RD_ADDR;
            // Array registers the first word here
            S_RD_ADDR: r_state_next = S_RD_DATA;
            S_RD_DATA: if (w_rend) r_state_next = S_IDLE;
            default:   r_state_next = S_IDLE;
        endcase
    end

    always_ff @(posedge i_aclk) begin
        if (!i_areset_n || w_arshake) begin
            r_arlen_cnt <= '0;
        end
        else if (w_rshake) begin
            r_arlen_cnt <= r_arlen_cnt + 8'd1;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (w_arshake) begin
            r_arid    <= i_ar.id;
            r_araddr  <= i_ar.addr;
            r_arlen   <= i_ar.len;
            r_arburst <= i_ar.burst;
            r_arerr   <= w_arerr;
        end
        else if (w_rshake) begin
            r_araddr <= w_araddr_next;
        end
    end

    // Next word on a handshake, otherwise reload the stalled one
    assign w_raddr     = w_rshake ? w_araddr_next : r_araddr;
    assign o_mem_raddr = w_raddr[MEM_ADDR_W+2:3];

    // ==========================================================
    // Outputs
    // ==========================================================
    assign o_arready = (r_state_curr == S_IDLE);
    assign o_rvalid  = (r_state_curr == S_RD_DATA);

    assign o_r.id   = r_arid;
    assign o_r.data = r_arerr ? '0 : i_mem_rdata;
    assign o_r.resp = r_arerr ? sram_pkg::RESP_SLVERR : sram_pkg::RESP_OKAY;
    assign o_r.last = w_rlast;

endmodule

//--- hdl/sram_slave.sv
`timescale 1ns/1ps

module sram_slave #(
    // Word address bits, memory holds 2**MEM_ADDR_W words
    parameter int MEM_ADDR_W = 8
) (
    input  logic                  i_aclk,
    input  logic                  i_areset_n,
    // Write address
    input  sram_pkg::sram_cmd_t   i_aw,
    input  logic                  i_awvalid,
    output logic                  o_awready,
    // Write data
    input  sram_pkg::sram_wbeat_t i_w,
    input  logic                  i_wvalid,
    output logic                  o_wready,
    // Write response
    output sram_pkg::sram_bresp_t o_b,
    output logic                  o_bvalid,
    input  logic                  i_bready,
    // Read address
    input  sram_pkg::sram_cmd_t   i_ar,
    input  logic                  i_arvalid,
    output logic                  o_arready,
    // Read data
    output sram_pkg::sram_rbeat_t o_r,
    output logic                  o_rvalid,
    input  logic                  i_rready
);

    // ==========================================================
    // Array ports
    // ==========================================================
    logic                  w_mem_we;
    logic [MEM_ADDR_W-1:0] w_mem_waddr;
    sram_pkg::axi_data_t   w_mem_wdata;
    sram_pkg::axi_strb_t   w_mem_wstrb;
    logic [MEM_ADDR_W-1:0] w_mem_raddr;
    sram_pkg::axi_data_t   w_mem_rdata;

    // Input side
    sram_wr_ctrl #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) wr_ctrl_i (
        .i_aclk      (i_aclk),
        .i_areset_n  (i_areset_n),
        .i_aw        (i_aw),
        .i_awvalid   (i_awvalid),
        .o_awready   (o_awready),
        .i_w         (i_w),
        .i_wvalid    (i_wvalid),
        .o_wready    (o_wready),
        .o_b         (o_b),
        .o_bvalid    (o_bvalid),
        .i_bready    (i_bready),
        .o_mem_we    (w_mem_we),
        .o_mem_addr  (w_mem_waddr),
        .o_mem_wdata (w_mem_wdata),
        .o_mem_wstrb (w_mem_wstrb)
    );

    // Processing part, independent write and read ports
    sram_array #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) array_i (
        .i_aclk  (i_aclk),
        .i_we    (w_mem_we),
        .i_waddr (w_mem_waddr),
        .i_wdata (w_mem_wdata),
        .i_wstrb (w_mem_wstrb),
        .i_raddr (w_mem_raddr),
        .o_rdata (w_mem_rdata)
    );

    // Output side
    sram_rd_ctrl #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) rd_ctrl_i (
        .i_aclk      (i_aclk),
        .i_areset_n  (i_areset_n),
        .i_ar        (i_ar),
        .i_arvalid   (i_arvalid),
        .o_arready   (o_arready),
        .o_r         (o_r),
        .o_rvalid    (o_rvalid),
        .i_rready    (i_rready),
        .o_mem_raddr (w_mem_raddr),
        .i_mem_rdata (w_mem_rdata)
    );

endmodule

//--- tests/tb_sram_slave.sv
`timescale 1ns/1ps

module tb_sram_slave;

    localparam int MEM_ADDR_W = 8;
    localparam int BYTE_AW    = MEM_ADDR_W + 3;
    localparam int MEM_BYTES  = 2 ** BYTE_AW;
    localparam int WAIT_LIMIT = 100;
    localparam logic [31:0] LFSR_SEED = 32'd73789;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
    localparam sram_pkg::axi_burst_t BURST_RESERVED = 2'b11;

    logic                  aclk = 1'b0;
    logic                  areset_n;
    sram_pkg::sram_cmd_t   aw_cmd;
    logic                  awvalid;
    logic                  awready;
    sram_pkg::sram_wbeat_t w_beat;
    logic                  wvalid;
    logic                  wready;
    sram_pkg::sram_bresp_t b_resp;
    logic                  bvalid;
    logic                  bready;
    sram_pkg::sram_cmd_t   ar_cmd;
    logic                  arvalid;
    logic                  arready;
    sram_pkg::sram_rbeat_t r_beat;
    logic                  rvalid;
    logic                  rready;

    // Byte image of the memory
    logic [7:0]  ref_mem [0:MEM_BYTES-1];
    logic [31:0] lfsr = LFSR_SEED;

    logic                  rd_stalled = 1'b0;
    sram_pkg::sram_rbeat_t rd_held;
    logic                  b_stalled = 1'b0;
    sram_pkg::sram_bresp_t b_held;

    always #50 aclk = ~aclk;

    sram_slave #(
        .MEM_ADDR_W (MEM_ADDR_W)
    ) sram_slave_i (
        .i_aclk     (aclk),
        .i_areset_n (areset_n),
        .i_aw       (aw_cmd),
        .i_awvalid  (awvalid),
        .o_awready  (awready),
        .i_w        (w_beat),
        .i_wvalid   (wvalid),
        .o_wready   (wready),
        .o_b        (b_resp),
        .o_bvalid   (bvalid),
        .i_bready   (bready),
        .i_ar       (ar_cmd),
        .i_arvalid  (arvalid),
        .o_arready  (arready),
        .o_r        (r_beat),
        .o_rvalid   (rvalid),
        .i_rready   (rready)
    );

    // ============================================================
    // Error reporting
    // ============================================================
    task automatic stop_on_error();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [71:0] expected,
                                   input logic [71:0] actual);
        $display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
        stop_on_error();
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns: no %s within %0d cycles", $time, what, WAIT_LIMIT);
        stop_on_error();
    endtask

    // ============================================================
    // Random bits and reference model
    // ============================================================
    function automatic logic [31:0] lfsr_step(logic [31:0] state);
        logic [31:0] state_next;
        state_next = state >> 1;
        if (state[0]) begin
            state_next = state_next ^ LFSR_TAPS;
        end
        return state_next;
    endfunction

    // One LFSR step per bit taken
    task automatic draw_bits(input int count, output logic [63:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < count; i++) begin
            lfsr = lfsr_step(lfsr);
            bits = {bits[62:0], lfsr[0]};
        end
    endtask

    function automatic sram_pkg::sram_cmd_t make_cmd(int id, int addr, int len, int size,
                                                     sram_pkg::axi_burst_t burst);
        sram_pkg::sram_cmd_t cmd;
        cmd.id    = sram_pkg::axi_id_t'(id);
        cmd.addr  = sram_pkg::axi_addr_t'(addr);
        cmd.len   = sram_pkg::axi_len_t'(len);
        cmd.size  = sram_pkg::axi_size_t'(size);
        cmd.burst = burst;
        return cmd;
    endfunction

    function automatic logic burst_is_error(sram_pkg::sram_cmd_t cmd);
        return (cmd.size != sram_pkg::SIZE_8B) || (cmd.burst == BURST_RESERVED) ||
               (int'(cmd.addr) >= MEM_BYTES);
    endfunction

    // Byte address of beat number beat within a burst
    function automatic int beat_addr(sram_pkg::sram_cmd_t cmd, int beat);
        int start;
        int window;
        int base;
        int addr;
        start  = int'(cmd.addr);
        window = (int'(cmd.len) + 1) * 8;
        base   = start - (start % window);
        case (cmd.burst)
            sram_pkg::BURST_FIXED: addr = start;
            sram_pkg::BURST_WRAP:  addr = base + ((start - base + beat * 8) % window);
            default:               addr = start + beat * 8;
        endcase
        return addr;
    endfunction

    function automatic sram_pkg::axi_data_t ref_word(int addr);
        sram_pkg::axi_data_t word;
        logic [BYTE_AW-1:0]  idx;
        int k;
        for (k = 0; k < 8; k++) begin
            idx = BYTE_AW'(((addr % MEM_BYTES) & ~7) + k);
            word[8*k +: 8] = ref_mem[idx];
        end
        return word;
    endfunction

    function automatic void ref_write(int addr, sram_pkg::axi_data_t data,
                                      sram_pkg::axi_strb_t strb);
        logic [BYTE_AW-1:0] idx;
        int k;
        for (k = 0; k < 8; k++) begin
            idx = BYTE_AW'(((addr % MEM_BYTES) & ~7) + k);
            if (strb[k]) begin
                ref_mem[idx] = data[8*k +: 8];
            end
        end
    endfunction

    // ============================================================
    // Bus transfers
    // ============================================================
    // Tasks start and end 1 ns after a rising edge
    task automatic write_burst(input sram_pkg::sram_cmd_t cmd, input bit rand_strb,
                               input bit stall_b);
        logic [63:0]         bits;
        sram_pkg::axi_data_t data;
        sram_pkg::axi_strb_t strb;
        sram_pkg::axi_resp_t exp_resp;
        logic                err;
        logic                done;
        int                  waited;
        int                  beat;
        err      = burst_is_error(cmd);
        exp_resp = err ? sram_pkg::RESP_SLVERR : sram_pkg::RESP_OKAY;
        aw_cmd   = cmd;
        awvalid  = 1'b1;
        done     = 1'b0;
        waited   = 0;
        while (!done) begin
            @(negedge aclk);
            done = awready;
            @(posedge aclk);
            #1;
            waited++;
            if (!done && waited >= WAIT_LIMIT) report_timeout("AW handshake");
        end
        awvalid = 1'b0;

        for (beat = 0; beat <= int'(cmd.len); beat++) begin
            draw_bits(64, bits);
            data = bits;
            if (rand_strb) begin
                draw_bits(8, bits);
                strb = bits[7:0];
            end
            else begin
                strb = '1;
            end
            // Error bursts leave the model untouched
            if (!err) begin
                ref_write(beat_addr(cmd, beat), data, strb);
            end
            w_beat.data = data;
            w_beat.strb = strb;
            wvalid      = 1'b1;
            done        = 1'b0;
            waited      = 0;
            while (!done) begin
                @(negedge aclk);
                done = wready;
                @(posedge aclk);
                #1;
                waited++;
                if (!done && waited >= WAIT_LIMIT) report_timeout("W handshake");
            end
        end
        wvalid = 1'b0;

        done   = 1'b0;
        waited = 0;
        while (!done) begin
            if (stall_b) begin
                draw_bits(1, bits);
                bready = bits[0];
            end
            else begin
                bready = 1'b1;
            end
            @(negedge aclk);
            if (bvalid && bready) begin
                done = 1'b1;
                assert (b_resp.id == cmd.id)
                    else report_mismatch("o_b.id", 72'(cmd.id), 72'(b_resp.id));
                assert (b_resp.resp == exp_resp)
                    else report_mismatch("o_b.resp", 72'(exp_resp), 72'(b_resp.resp));
            end
            @(posedge aclk);
            #1;
            waited++;
            if (!done && waited >= WAIT_LIMIT) report_timeout("B handshake");
        end
        bready = 1'b0;
    endtask

    task automatic read_burst(input sram_pkg::sram_cmd_t cmd, input bit stall_r);
        logic [63:0]         bits;
        sram_pkg::axi_data_t exp_data;
        sram_pkg::axi_resp_t exp_resp;
        logic                exp_last;
        logic                err;
        logic                done;
        int                  waited;
        int                  beat;
        err      = burst_is_error(cmd);
        exp_resp = err ? sram_pkg::RESP_SLVERR : sram_pkg::RESP_OKAY;
        ar_cmd   = cmd;
        arvalid  = 1'b1;
        done     = 1'b0;
        waited   = 0;
        while (!done) begin
            @(negedge aclk);
            done = arready;
            @(posedge aclk);
            #1;
            waited++;
            if (!done && waited >= WAIT_LIMIT) report_timeout("AR handshake");
        end
        arvalid = 1'b0;

        for (beat = 0; beat <= int'(cmd.len); beat++) begin
            exp_data = err ? '0 : ref_word(beat_addr(cmd, beat));
            exp_last = (beat == int'(cmd.len));
            done     = 1'b0;
            waited   = 0;
            while (!done) begin
                if (stall_r) begin
                    draw_bits(1, bits);
                    rready = bits[0];
                end
                else begin
                    rready = 1'b1;
                end
                @(negedge aclk);
                if (rvalid && rready) begin
                    done = 1'b1;
                    assert (r_beat.id == cmd.id)
                        else report_mismatch("o_r.id", 72'(cmd.id), 72'(r_beat.id));
                    assert (r_beat.data == exp_data)
                        else report_mismatch("o_r.data", 72'(exp_data), 72'(r_beat.data));
                    assert (r_beat.resp == exp_resp)
                        else report_mismatch("o_r.resp", 72'(exp_resp), 72'(r_beat.resp));
                    assert (r_beat.last == exp_last)
                        else report_mismatch("o_r.last", 72'(exp_last), 72'(r_beat.last));
                end
                @(posedge aclk);
                #1;
                waited++;
                if (!done && waited >= WAIT_LIMIT) report_timeout("R handshake");
            end
        end
        rready = 1'b0;

        // No beat may follow rlast
        @(negedge aclk);
        assert (!rvalid) else report_mismatch("o_rvalid after rlast", 72'd0, 72'(rvalid));
        @(posedge aclk);
        #1;
    endtask

    task automatic check_reset_values();
        @(negedge aclk);
        assert (!rvalid)  else report_mismatch("o_rvalid", 72'd0, 72'(rvalid));
        assert (!bvalid)  else report_mismatch("o_bvalid", 72'd0, 72'(bvalid));
        assert (!wready)  else report_mismatch("o_wready", 72'd0, 72'(wready));
        assert (arready)  else report_mismatch("o_arready", 72'd1, 72'(arready));
        assert (awready)  else report_mismatch("o_awready", 72'd1, 72'(awready));
        @(posedge aclk);
        #1;
    endtask

    // ============================================================
    // Protocol checks
    // ============================================================
    // First beat rises at the edge after the AR handshake edge, not earlier
    rvalid_after_ar: assert property (@(posedge aclk) disable iff (!areset_n)
        $past(arvalid && arready, 2) |-> (rvalid && !$past(rvalid)))
        else report_mismatch("o_rvalid one cycle after AR", 72'd1, 72'd0);

    rvalid_held: assert property (@(posedge aclk) disable iff (!areset_n)
        (rvalid && !rready) |=> rvalid)
        else report_mismatch("o_rvalid while stalled", 72'd1, 72'd0);

    bvalid_held: assert property (@(posedge aclk) disable iff (!areset_n)
        (bvalid && !bready) |=> bvalid)
        else report_mismatch("o_bvalid while stalled", 72'd1, 72'd0);

    // Stalled payloads must not move
    always @(negedge aclk) begin
        if (rd_stalled) begin
            assert (r_beat == rd_held)
                else report_mismatch("o_r while stalled", 72'(rd_held), 72'(r_beat));
        end
        if (b_stalled) begin
            assert (b_resp == b_held)
                else report_mismatch("o_b while stalled", 72'(b_held), 72'(b_resp));
        end
        rd_stalled = areset_n && rvalid && !rready;
        rd_held    = r_beat;
        b_stalled  = areset_n && bvalid && !bready;
        b_held     = b_resp;
    end

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        areset_n = 1'b0;
        aw_cmd   = '0;
        awvalid  = 1'b0;
        w_beat   = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        ar_cmd   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        repeat (2) @(posedge aclk);
        #1;
        areset_n = 1'b1;
        check_reset_values();

        // Plain INCR write and read back
        write_burst(make_cmd(3, 'h100, 15, 3, sram_pkg::BURST_INCR), 1'b0, 1'b0);
        read_burst(make_cmd(5, 'h100, 15, 3, sram_pkg::BURST_INCR), 1'b0);

        // Partial strobes over known data
        write_burst(make_cmd(6, 'h100, 3, 3, sram_pkg::BURST_INCR), 1'b1, 1'b0);
        read_burst(make_cmd(7, 'h100, 3, 3, sram_pkg::BURST_INCR), 1'b0);

        // FIXED keeps only the last beat
        write_burst(make_cmd(8, 'h200, 3, 3, sram_pkg::BURST_FIXED), 1'b0, 1'b0);
        read_burst(make_cmd(9, 'h200, 0, 3, sram_pkg::BURST_INCR), 1'b0);
        read_burst(make_cmd(10, 'h200, 2, 3, sram_pkg::BURST_FIXED), 1'b0);

        // WRAP from word 2 of a 32-byte block
        write_burst(make_cmd(11, 'h300, 3, 3, sram_pkg::BURST_INCR), 1'b0, 1'b0);
        read_burst(make_cmd(12, 'h310, 3, 3, sram_pkg::BURST_WRAP), 1'b0);

        // Error bursts, then memory unchanged
        write_burst(make_cmd(1, 'h100, 3, 2, sram_pkg::BURST_INCR), 1'b0, 1'b0);
        read_burst(make_cmd(2, 'h100, 3, 2, sram_pkg::BURST_INCR), 1'b0);
        write_burst(make_cmd(13, 'h108, 1, 3, BURST_RESERVED), 1'b0, 1'b0);
        read_burst(make_cmd(14, 'h108, 1, 3, BURST_RESERVED), 1'b0);
        // Low address bits alias onto the range read back below
        write_burst(make_cmd(15, MEM_BYTES + 'h100, 1, 3, sram_pkg::BURST_INCR), 1'b0, 1'b0);
        read_burst(make_cmd(0, MEM_BYTES + 'h40, 1, 3, sram_pkg::BURST_INCR), 1'b0);
        read_burst(make_cmd(4, 'h100, 15, 3, sram_pkg::BURST_INCR), 1'b0);

        // Long bursts under random back-pressure
        write_burst(make_cmd(9, 'h400, 63, 3, sram_pkg::BURST_INCR), 1'b0, 1'b1);
        read_burst(make_cmd(10, 'h400, 63, 3, sram_pkg::BURST_INCR), 1'b1);
        read_burst(make_cmd(11, 'h438, 7, 3, sram_pkg::BURST_WRAP), 1'b1);

        // Read and write in flight together, disjoint ranges
        fork
            write_burst(make_cmd(12, 'h600, 31, 3, sram_pkg::BURST_INCR), 1'b0, 1'b1);
            read_burst(make_cmd(13, 'h400, 31, 3, sram_pkg::BURST_INCR), 1'b1);
        join
        read_burst(make_cmd(14, 'h600, 31, 3, sram_pkg::BURST_INCR), 1'b1);

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- sram_slave.f
hdl/sram_pkg.sv
hdl/sram_burst_addr.sv
hdl/sram_array.sv
hdl/sram_wr_ctrl.sv
hdl/sram_rd_ctrl.sv
hdl/sram_slave.sv
tests/tb_sram_slave.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the SRAM slave testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

TOP=tb_sram_slave
BUILD_DIR=obj_dir
LOG_FILE=sim.log
FAIL_MSG="FAIL: see errors above"

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" --Mdir "$BUILD_DIR" -f sram_slave.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

grep -qF "$FAIL_MSG" "$LOG_FILE"
grep_status=$?
if [ $grep_status -eq 0 ]; then
    echo "Simulation failed"
    exit 1
elif [ $grep_status -ne 1 ]; then
    echo "Could not search $LOG_FILE"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

echo "Simulation passed"
exit 0
